// ==== source/simd_pkg.sv ====
/*
 * Shared types and constants of the vector execution stage
 * Element and lane widths, SEW and operation encodings
 */
`default_nettype none

package simd_pkg;

    localparam int ELEM_W     = 64;   // Width of one lane
    localparam int MUL_STAGES = 3;    // Multiply latency in cycles

    typedef logic [ELEM_W-1:0] elem_t;
    typedef logic [4:0]        vreg_tag_t;   // Destination vector register
    typedef logic [7:0]        vl_t;         // Vector length in elements

    typedef enum logic [1:0] {
        SEW_8,
        SEW_16,
        SEW_32,
        SEW_64
    } sew_t;

    typedef enum logic [2:0] {
        VADD,
        VSUB,
        VAND,
        VOR,
        VXOR,
        VMUL,
        VMV_X_S
    } vop_t;

endpackage

`default_nettype wire

// ==== source/operand_prep.sv ====
/*
 * Operand preparation for the vs1 side of the lanes
 * Replicates rs1 by SEW for the .vx form, or passes vs1
 */
`timescale 1ns/1ps
`default_nettype none

module operand_prep
    import simd_pkg::*;
#(
    parameter int VLEN = 128
) (
    input  wire sew_t            sew_i,
    input  wire                  scalar_src_i,
    input  wire elem_t           data_rs1_i,
    input  wire [VLEN-1:0]       data_vs1_i,
    output logic [VLEN-1:0]      vs1_lanes_o
);

    localparam int LANES = VLEN / ELEM_W;

    logic [VLEN-1:0] rs1_rep;

    // Low SEW bits of rs1 copied into every element
    always_comb begin
        case (sew_i)
            SEW_8: begin
                rs1_rep = {(VLEN/8){data_rs1_i[7:0]}};
            end
            SEW_16: begin
                rs1_rep = {(VLEN/16){data_rs1_i[15:0]}};
            end
            SEW_32: begin
                rs1_rep = {(VLEN/32){data_rs1_i[31:0]}};
            end
            default: begin
                rs1_rep = {LANES{data_rs1_i}};
            end
        endcase
    end

    assign vs1_lanes_o = scalar_src_i ? rs1_rep : data_vs1_i;

endmodule

`default_nettype wire

// ==== source/lane_fu.sv ====
/*
 * One 64-bit lane of the vector unit
 * SEW-partitioned add, sub and logic ops with a single result register
 * SEW-partitioned multiply through a MUL_STAGES deep register chain
 */
`timescale 1ns/1ps
`default_nettype none

module lane_fu
    import simd_pkg::*;
(
    input  wire         clk_i,
    input  wire         rstn_i,
    input  wire vop_t   op_i,
    input  wire sew_t   sew_i,
    input  wire elem_t  a_i,      // vs2 element data
    input  wire elem_t  b_i,      // vs1 or replicated rs1
    output elem_t       alu_res_o,
    output elem_t       mul_res_o
);

    elem_t      b_op;
    elem_t      addsub_res;
    elem_t      alu_d;
    elem_t      mul_d;
    elem_t      alu_q;
    elem_t      mul_q [MUL_STAGES];
    logic [8:0] byte_sum;
    logic       carry;

    // Byte-wise ripple, carry chain restarts at every element boundary
    always_comb begin
        b_op  = (op_i == VSUB) ? ~b_i : b_i;
        carry = 1'b0;
        for (int j = 0; j < ELEM_W/8; j++) begin
            if ((j % (1 << sew_i)) == 0) begin
                carry = (op_i == VSUB);   // +1 of the two's complement
            end
            byte_sum = {1'b0, a_i[j*8 +: 8]} + {1'b0, b_op[j*8 +: 8]} + {8'b0, carry};
            addsub_res[j*8 +: 8] = byte_sum[7:0];
            carry = byte_sum[8];
        end
    end

    always_comb begin
        case (op_i)
            VADD, VSUB: alu_d = addsub_res;
            VAND:       alu_d = a_i & b_i;
            VOR:        alu_d = a_i | b_i;
            VXOR:       alu_d = a_i ^ b_i;
            default:    alu_d = a_i;
        endcase
    end

    // Low half of each element product
    always_comb begin
        mul_d = '0;
        case (sew_i)
            SEW_8: begin
                for (int k = 0; k < ELEM_W/8; k++) begin
                    mul_d[k*8 +: 8] = a_i[k*8 +: 8] * b_i[k*8 +: 8];
                end
            end
            SEW_16: begin
                for (int k = 0; k < ELEM_W/16; k++) begin
                    mul_d[k*16 +: 16] = a_i[k*16 +: 16] * b_i[k*16 +: 16];
                end
            end
            SEW_32: begin
                for (int k = 0; k < ELEM_W/32; k++) begin
                    mul_d[k*32 +: 32] = a_i[k*32 +: 32] * b_i[k*32 +: 32];
                end
            end
            default: begin
                mul_d = a_i * b_i;
            end
        endcase
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            alu_q <= '0;
            for (int s = 0; s < MUL_STAGES; s++) begin
                mul_q[s] <= '0;
            end
        end else begin
            alu_q    <= alu_d;
            mul_q[0] <= mul_d;
            for (int s = 1; s < MUL_STAGES; s++) begin
                mul_q[s] <= mul_q[s-1];
            end
        end
    end

    assign alu_res_o = alu_q;
    assign mul_res_o = mul_q[MUL_STAGES-1];

endmodule

`default_nettype wire

// ==== source/latency_tracker.sv ====
/*
 * Instruction latency tracking
 * One-entry pipe for single-cycle ops, MUL_STAGES-entry pipe for multiplies
 * Reports the instruction that completes this cycle, multiply first
 */
`timescale 1ns/1ps
`default_nettype none

module latency_tracker
    import simd_pkg::*;
#(
    parameter int VLEN = 128
) (
    input  wire              clk_i,
    input  wire              rstn_i,
    input  wire              valid_i,
    input  wire vop_t        op_i,
    input  wire sew_t        sew_i,
    input  wire vreg_tag_t   vd_tag_i,
    input  wire vl_t         vl_i,
    input  wire              use_mask_i,
    input  wire [VLEN/8-1:0] data_vm_i,
    input  wire [VLEN-1:0]   data_old_vd_i,
    input  wire elem_t       vs2_elem0_i,
    output logic             done_o,
    output vop_t             done_op_o,
    output sew_t             done_sew_o,
    output vreg_tag_t        done_tag_o,
    output vl_t              done_vl_o,
    output logic             done_use_mask_o,
    output logic [VLEN/8-1:0] done_vm_o,
    output logic [VLEN-1:0]  done_old_vd_o,
    output elem_t            done_vs2_elem0_o
);

    localparam int CTRL_W = $bits(vop_t) + $bits(sew_t) + $bits(vreg_tag_t) + $bits(vl_t)
                            + 1 + VLEN/8 + VLEN + ELEM_W;

    logic [CTRL_W-1:0]      issue_ctrl;
    logic [CTRL_W-1:0]      done_ctrl;
    logic                   alu_valid_q;
    logic [CTRL_W-1:0]      alu_ctrl_q;
    logic [MUL_STAGES-1:0]  mul_valid_q;
    logic [CTRL_W-1:0]      mul_ctrl_q [MUL_STAGES];
    logic                   is_mul;
    logic [$bits(vop_t)-1:0] op_bits;
    logic [$bits(sew_t)-1:0] sew_bits;

    assign is_mul     = (op_i == VMUL);
    assign issue_ctrl = {op_i, sew_i, vd_tag_i, vl_i, use_mask_i, data_vm_i, data_old_vd_i,
                         vs2_elem0_i};

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            alu_valid_q <= 1'b0;
            mul_valid_q <= '0;
        end else begin
            alu_valid_q <= valid_i && !is_mul;
            mul_valid_q <= {mul_valid_q[MUL_STAGES-2:0], valid_i && is_mul};
        end
    end

    // Control fields follow the valids down each pipe
    always_ff @(posedge clk_i) begin
        alu_ctrl_q    <= issue_ctrl;
        mul_ctrl_q[0] <= issue_ctrl;
        for (int s = 1; s < MUL_STAGES; s++) begin
            mul_ctrl_q[s] <= mul_ctrl_q[s-1];
        end
    end

    // A multiply leaving its pipe hides a colliding single-cycle op
    assign done_o    = mul_valid_q[MUL_STAGES-1] | alu_valid_q;
    assign done_ctrl = mul_valid_q[MUL_STAGES-1] ? mul_ctrl_q[MUL_STAGES-1] : alu_ctrl_q;

    assign {op_bits, sew_bits, done_tag_o, done_vl_o, done_use_mask_o, done_vm_o,
            done_old_vd_o, done_vs2_elem0_o} = done_ctrl;
    assign done_op_o  = vop_t'(op_bits);
    assign done_sew_o = sew_t'(sew_bits);

endmodule

`default_nettype wire

// ==== source/result_writeback.sv ====
/*
 * Result writeback of the vector unit
 * Lane result select, mask and tail fill by SEW
 * Scalar extract of element 0 with sign extension
 */
`timescale 1ns/1ps
`default_nettype none

module result_writeback
    import simd_pkg::*;
#(
    parameter int VLEN = 128
) (
    input  wire              done_i,
    input  wire vop_t        done_op_i,
    input  wire sew_t        done_sew_i,
    input  wire vl_t         done_vl_i,
    input  wire              done_use_mask_i,
    input  wire [VLEN/8-1:0] done_vm_i,
    input  wire [VLEN-1:0]   done_old_vd_i,
    input  wire elem_t       done_vs2_elem0_i,
    input  wire [VLEN-1:0]   alu_lanes_i,
    input  wire [VLEN-1:0]   mul_lanes_i,
    output logic             vec_valid_o,
    output logic [VLEN-1:0]  vec_result_o,
    output logic             scalar_valid_o,
    output elem_t            scalar_result_o
);

    localparam int MASK_W = VLEN / 8;   // Bytes in the vector, also max element count

    logic [VLEN-1:0] lane_res;

    assign lane_res = (done_op_i == VMUL) ? mul_lanes_i : alu_lanes_i;

    // Each byte follows the element that holds it
    always_comb begin
        int unsigned elem_idx;
        vec_result_o = '1;
        for (int unsigned b = 0; b < MASK_W; b++) begin
            elem_idx = b >> done_sew_i;
            if (elem_idx >= 32'(done_vl_i)) begin
                vec_result_o[b*8 +: 8] = 8'hff;   // Tail
            end else if (done_use_mask_i && !done_vm_i[elem_idx]) begin
                vec_result_o[b*8 +: 8] = done_old_vd_i[b*8 +: 8];
            end else begin
                vec_result_o[b*8 +: 8] = lane_res[b*8 +: 8];
            end
        end
    end

    always_comb begin
        case (done_sew_i)
            SEW_8: begin
                scalar_result_o = {{56{done_vs2_elem0_i[7]}}, done_vs2_elem0_i[7:0]};
            end
            SEW_16: begin
                scalar_result_o = {{48{done_vs2_elem0_i[15]}}, done_vs2_elem0_i[15:0]};
            end
            SEW_32: begin
                scalar_result_o = {{32{done_vs2_elem0_i[31]}}, done_vs2_elem0_i[31:0]};
            end
            default: begin
                scalar_result_o = done_vs2_elem0_i;
            end
        endcase
    end

    assign vec_valid_o    = done_i && (done_op_i != VMV_X_S) && (done_vl_i != '0);
    assign scalar_valid_o = done_i && (done_op_i == VMV_X_S);

endmodule

`default_nettype wire

// ==== source/simd_unit.sv ====
/*
 * Vector execution stage top level
 * Operand prep, lane array, latency tracker and writeback
 */
`timescale 1ns/1ps
`default_nettype none

module simd_unit
    import simd_pkg::*;
#(
    parameter int VLEN = 128
) (
    input  wire              clk_i,
    input  wire              rstn_i,
    input  wire              valid_i,
    input  wire vop_t        op_i,
    input  wire sew_t        sew_i,
    input  wire vreg_tag_t   vd_tag_i,
    input  wire vl_t         vl_i,
    input  wire              scalar_src_i,   // vs1 taken from replicated rs1
    input  wire              use_mask_i,
    input  wire elem_t       data_rs1_i,
    input  wire [VLEN-1:0]   data_vs1_i,
    input  wire [VLEN-1:0]   data_vs2_i,
    input  wire [VLEN-1:0]   data_old_vd_i,
    input  wire [VLEN/8-1:0] data_vm_i,
    output logic             vec_valid_o,
    output vreg_tag_t        vec_tag_o,
    output logic [VLEN-1:0]  vec_result_o,
    output logic             scalar_valid_o,
    output elem_t            scalar_result_o
);

    localparam int LANES = VLEN / ELEM_W;

    logic [VLEN-1:0]   vs1_lanes;
    logic [VLEN-1:0]   alu_lanes;
    logic [VLEN-1:0]   mul_lanes;
    logic              done;
    vop_t              done_op;
    sew_t              done_sew;
    vl_t               done_vl;
    logic              done_use_mask;
    logic [VLEN/8-1:0] done_vm;
    logic [VLEN-1:0]   done_old_vd;
    elem_t             done_vs2_elem0;

    operand_prep #(.VLEN(VLEN)) u_operand_prep (
        .sew_i        (sew_i),
        .scalar_src_i (scalar_src_i),
        .data_rs1_i   (data_rs1_i),
        .data_vs1_i   (data_vs1_i),
        .vs1_lanes_o  (vs1_lanes)
    );

    for (genvar l = 0; l < LANES; l++) begin : g_lane
        lane_fu u_lane_fu (
            .clk_i     (clk_i),
            .rstn_i    (rstn_i),
            .op_i      (op_i),
            .sew_i     (sew_i),
            .a_i       (data_vs2_i[l*ELEM_W +: ELEM_W]),
            .b_i       (vs1_lanes[l*ELEM_W +: ELEM_W]),
            .alu_res_o (alu_lanes[l*ELEM_W +: ELEM_W]),
            .mul_res_o (mul_lanes[l*ELEM_W +: ELEM_W])
        );
    end

    latency_tracker #(.VLEN(VLEN)) u_latency_tracker (
        .clk_i            (clk_i),
        .rstn_i           (rstn_i),
        .valid_i          (valid_i),
        .op_i             (op_i),
        .sew_i            (sew_i),
        .vd_tag_i         (vd_tag_i),
        .vl_i             (vl_i),
        .use_mask_i       (use_mask_i),
        .data_vm_i        (data_vm_i),
        .data_old_vd_i    (data_old_vd_i),
        .vs2_elem0_i      (data_vs2_i[ELEM_W-1:0]),
        .done_o           (done),
        .done_op_o        (done_op),
        .done_sew_o       (done_sew),
        .done_tag_o       (vec_tag_o),
        .done_vl_o        (done_vl),
        .done_use_mask_o  (done_use_mask),
        .done_vm_o        (done_vm),
        .done_old_vd_o    (done_old_vd),
        .done_vs2_elem0_o (done_vs2_elem0)
    );

    result_writeback #(.VLEN(VLEN)) u_result_writeback (
        .done_i           (done),
        .done_op_i        (done_op),
        .done_sew_i       (done_sew),
        .done_vl_i        (done_vl),
        .done_use_mask_i  (done_use_mask),
        .done_vm_i        (done_vm),
        .done_old_vd_i    (done_old_vd),
        .done_vs2_elem0_i (done_vs2_elem0),
        .alu_lanes_i      (alu_lanes),
        .mul_lanes_i      (mul_lanes),
        .vec_valid_o      (vec_valid_o),
        .vec_result_o     (vec_result_o),
        .scalar_valid_o   (scalar_valid_o),
        .scalar_result_o  (scalar_result_o)
    );

endmodule

`default_nettype wire

// ==== testbench/clock_gen.sv ====
/*
 * Testbench clock and reset generator
 */
`timescale 1ns/1ps
`default_nettype none

module clock_gen #(
    parameter int PERIOD_NS    = 10,
    parameter int RESET_CYCLES = 8
) (
    output logic clk_o,
    output logic rstn_o
);

    initial begin
        clk_o = 1'b0;
        forever #(PERIOD_NS / 2) clk_o = ~clk_o;
    end

    initial begin
        rstn_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1 rstn_o = 1'b1;   // Released just after an edge
    end

endmodule

`default_nettype wire

// ==== testbench/tb_simd_unit.sv ====
/*
 * Testbench of the vector execution stage
 * Stimulus table, reference model, expected-result queue, compare tasks, watchdog
 */
`timescale 1ns/1ps
`default_nettype none

module tb_simd_unit
    import simd_pkg::*;
();

    localparam int          VLEN    = 128;
    localparam int          MASK_W  = VLEN / 8;
    localparam int unsigned MUL_LAT = 3;
    localparam logic [31:0] SEED    = 32'h6b38_69aa;

    typedef struct packed {
        vop_t              op;
        sew_t              sew;
        logic              scalar_src;
        logic              use_mask;
        vl_t               vl;
        vreg_tag_t         tag;
        int unsigned       gap;        // Idle cycles after this row
        elem_t             rs1;
        logic [VLEN-1:0]   vs1;
        logic [VLEN-1:0]   vs2;
        logic [VLEN-1:0]   old_vd;
        logic [MASK_W-1:0] vm;
    } row_t;

    typedef struct packed {
        int unsigned     cyc;         // Cycle in which the result is due
        logic            is_scalar;
        vreg_tag_t       tag;
        logic [VLEN-1:0] vec;
        elem_t           scalar;
    } exp_t;

    logic              clk_i;
    logic              rstn_i;
    logic              valid_i;
    vop_t              op_i;
    sew_t              sew_i;
    vreg_tag_t         vd_tag_i;
    vl_t               vl_i;
    logic              scalar_src_i;
    logic              use_mask_i;
    elem_t             data_rs1_i;
    logic [VLEN-1:0]   data_vs1_i;
    logic [VLEN-1:0]   data_vs2_i;
    logic [VLEN-1:0]   data_old_vd_i;
    logic [MASK_W-1:0] data_vm_i;
    logic              vec_valid_o;
    vreg_tag_t         vec_tag_o;
    logic [VLEN-1:0]   vec_result_o;
    logic              scalar_valid_o;
    elem_t             scalar_result_o;

    row_t        rows [$];
    exp_t        expq [$];
    sew_t        sew_list [4];
    vop_t        alu_list [5];
    int unsigned cyc = 0;
    int          mismatch_errs = 0;
    int          other_errs = 0;

    clock_gen #(.PERIOD_NS(10), .RESET_CYCLES(8)) u_clock_gen (
        .clk_o  (clk_i),
        .rstn_o (rstn_i)
    );

    simd_unit #(.VLEN(VLEN)) dut_i (
        .clk_i           (clk_i),
        .rstn_i          (rstn_i),
        .valid_i         (valid_i),
        .op_i            (op_i),
        .sew_i           (sew_i),
        .vd_tag_i        (vd_tag_i),
        .vl_i            (vl_i),
        .scalar_src_i    (scalar_src_i),
        .use_mask_i      (use_mask_i),
        .data_rs1_i      (data_rs1_i),
        .data_vs1_i      (data_vs1_i),
        .data_vs2_i      (data_vs2_i),
        .data_old_vd_i   (data_old_vd_i),
        .data_vm_i       (data_vm_i),
        .vec_valid_o     (vec_valid_o),
        .vec_tag_o       (vec_tag_o),
        .vec_result_o    (vec_result_o),
        .scalar_valid_o  (scalar_valid_o),
        .scalar_result_o (scalar_result_o)
    );

    always @(posedge clk_i) cyc <= cyc + 32'd1;

    function automatic int unsigned elem_count(sew_t s);
        return VLEN / (32'd8 << s);
    endfunction

    function automatic logic [VLEN-1:0] rand_vec();
        logic [VLEN-1:0] v;
        v = '0;
        for (int w = 0; w < VLEN / 32; w++) begin
            v[w*32 +: 32] = $urandom;
        end
        return v;
    endfunction

    // Per-element model: tail, then mask, then the op modulo 2^SEW
    function automatic logic [VLEN-1:0] ref_vec(row_t r);
        int unsigned     ew;
        elem_t           emask;
        elem_t           a;
        elem_t           b;
        elem_t           y;
        logic [VLEN-1:0] res;
        ew    = 32'd8 << r.sew;
        emask = (ew == 32'd64) ? '1 : ((64'd1 << ew) - 64'd1);
        res   = '0;
        for (int unsigned i = 0; i < elem_count(r.sew); i++) begin
            a = elem_t'(r.vs2 >> (i * ew)) & emask;
            b = r.scalar_src ? (r.rs1 & emask) : (elem_t'(r.vs1 >> (i * ew)) & emask);
            case (r.op)
                VADD:    y = a + b;
                VSUB:    y = a - b;
                VAND:    y = a & b;
                VOR:     y = a | b;
                VXOR:    y = a ^ b;
                VMUL:    y = a * b;
                default: y = a;
            endcase
            if (i >= 32'(r.vl)) begin
                y = emask;
            end else if (r.use_mask && !r.vm[i]) begin
                y = elem_t'(r.old_vd >> (i * ew));
            end
            res = res | (VLEN'(y & emask) << (i * ew));
        end
        return res;
    endfunction

    function automatic elem_t ref_scalar(row_t r);
        int unsigned ew;
        elem_t       emask;
        elem_t       e;
        ew    = 32'd8 << r.sew;
        emask = (ew == 32'd64) ? '1 : ((64'd1 << ew) - 64'd1);
        e     = r.vs2[ELEM_W-1:0] & emask;
        if (e[ew-1]) e = e | ~emask;   // Sign extension
        return e;
    endfunction

    task automatic add_row(input vop_t op, input sew_t sew, input logic scalar_src,
                           input logic use_mask, input int unsigned vl, input int unsigned gap);
        row_t r;
        r.op         = op;
        r.sew        = sew;
        r.scalar_src = scalar_src;
        r.use_mask   = use_mask;
        r.vl         = vl_t'(vl);
        r.tag        = vreg_tag_t'(rows.size());
        r.gap        = gap;
        r.rs1        = {$urandom, $urandom};
        r.vs1        = rand_vec();
        r.vs2        = rand_vec();
        r.old_vd     = rand_vec();
        r.vm         = MASK_W'($urandom);
        rows.push_back(r);
    endtask

    // A single-cycle op never follows a multiply by exactly two cycles
    task automatic build_table();
        int unsigned n;
        sew_list = '{SEW_8, SEW_16, SEW_32, SEW_64};
        alu_list = '{VADD, VSUB, VAND, VOR, VXOR};
        foreach (sew_list[s]) begin
            foreach (alu_list[k]) begin
                add_row(alu_list[k], sew_list[s], 1'b0, 1'b0, elem_count(sew_list[s]), 0);
            end
        end
        foreach (sew_list[s]) begin
            n = elem_count(sew_list[s]);
            add_row(VADD, sew_list[s], 1'b1, 1'b0, n, 0);   // .vx form
            add_row(VXOR, sew_list[s], 1'b1, 1'b0, n, 0);
            add_row(VSUB, sew_list[s], 1'b0, 1'b1, n, 0);
            add_row(VOR, sew_list[s], 1'b0, 1'b0, n / 2, 0);
            add_row(VAND, sew_list[s], 1'b0, 1'b1, n - 1, 0);
            add_row(VADD, sew_list[s], 1'b0, 1'b0, 0, 0);   // No pulse expected
        end
        foreach (sew_list[s]) begin
            n = elem_count(sew_list[s]);
            add_row(VMUL, sew_list[s], 1'b0, 1'b0, n, 0);
            add_row(VMUL, sew_list[s], 1'b1, 1'b0, n, 0);
            add_row(VMUL, sew_list[s], 1'b0, 1'b1, n - 1, 2);
            add_row(VMUL, sew_list[s], 1'b0, 1'b0, n, 0);
            add_row(VADD, sew_list[s], 1'b0, 1'b0, n, 0);
            add_row(VMUL, sew_list[s], 1'b0, 1'b0, n, 0);
            add_row(VAND, sew_list[s], 1'b0, 1'b0, n, 2);
        end
        foreach (sew_list[s]) begin
            add_row(VMV_X_S, sew_list[s], 1'b0, 1'b0, elem_count(sew_list[s]), 0);
        end
    endtask

    task automatic expect_result(input exp_t e);
        int pos;
        pos = expq.size();
        while (pos > 0 && expq[pos-1].cyc > e.cyc) pos--;
        expq.insert(pos, e);
    endtask

    task automatic drive_row(input row_t r);
        exp_t        e;
        int unsigned lat;
        valid_i       = 1'b1;
        op_i          = r.op;
        sew_i         = r.sew;
        vd_tag_i      = r.tag;
        vl_i          = r.vl;
        scalar_src_i  = r.scalar_src;
        use_mask_i    = r.use_mask;
        data_rs1_i    = r.rs1;
        data_vs1_i    = r.vs1;
        data_vs2_i    = r.vs2;
        data_old_vd_i = r.old_vd;
        data_vm_i     = r.vm;
        lat         = (r.op == VMUL) ? MUL_LAT : 32'd1;
        e.cyc       = cyc + lat;   // Sampled at the next edge, which is the first of lat
        e.is_scalar = (r.op == VMV_X_S);
        e.tag       = r.tag;
        e.vec       = ref_vec(r);
        e.scalar    = ref_scalar(r);
        if (e.is_scalar || r.vl != '0) expect_result(e);
    endtask

    task automatic check_vec(input string name, input logic [VLEN-1:0] got,
                             input logic [VLEN-1:0] exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatch_errs++;
        end
    endtask

    task automatic check_scalar(input string name, input elem_t got, input elem_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %h expected %h", $time, name, got, exp);
            mismatch_errs++;
        end
    endtask

    task automatic check_tag(input string name, input vreg_tag_t got, input vreg_tag_t exp);
        if (got !== exp) begin
            $display("mismatch at %0t: %s got %0d expected %0d", $time, name, got, exp);
            mismatch_errs++;
        end
    endtask

    task automatic check_outputs();
        while (expq.size() > 0 && expq[0].cyc < cyc) begin
            $display("error at %0t: result of tag %0d did not arrive in cycle %0d",
                     $time, expq[0].tag, expq[0].cyc);
            other_errs++;
            void'(expq.pop_front());
        end
        if (vec_valid_o) begin
            if (expq.size() > 0 && expq[0].cyc == cyc && !expq[0].is_scalar) begin
                check_vec("vec_result_o", vec_result_o, expq[0].vec);
                check_tag("vec_tag_o", vec_tag_o, expq[0].tag);
                void'(expq.pop_front());
            end else begin
                $display("error at %0t: vec_valid_o pulsed with no vector result due", $time);
                other_errs++;
            end
        end
        if (scalar_valid_o) begin
            if (expq.size() > 0 && expq[0].cyc == cyc && expq[0].is_scalar) begin
                check_scalar("scalar_result_o", scalar_result_o, expq[0].scalar);
                check_tag("vec_tag_o", vec_tag_o, expq[0].tag);
                void'(expq.pop_front());
            end else begin
                $display("error at %0t: scalar_valid_o pulsed with no scalar result due", $time);
                other_errs++;
            end
        end
    endtask

    always @(negedge clk_i) begin
        if (rstn_i) check_outputs();   // Outputs settle well before the falling edge
    end

    initial begin
        valid_i       = 1'b0;
        op_i          = VADD;
        sew_i         = SEW_8;
        vd_tag_i      = '0;
        vl_i          = '0;
        scalar_src_i  = 1'b0;
        use_mask_i    = 1'b0;
        data_rs1_i    = '0;
        data_vs1_i    = '0;
        data_vs2_i    = '0;
        data_old_vd_i = '0;
        data_vm_i     = '0;
        void'($urandom(SEED));
        build_table();
        @(posedge rstn_i);
        repeat (4) @(posedge clk_i);   // Idle after reset, valids must stay low
        for (int r = 0; r < rows.size(); r++) begin
            @(posedge clk_i);
            #1;
            drive_row(rows[r]);
            repeat (rows[r].gap) begin
                @(posedge clk_i);
                #1;
                valid_i = 1'b0;
            end
        end
        @(posedge clk_i);
        #1;
        valid_i = 1'b0;
        while (expq.size() != 0) @(posedge clk_i);
        repeat (4) @(posedge clk_i);
        $display("error count: %0d mismatches, %0d other", mismatch_errs, other_errs);
        if (mismatch_errs == 0 && other_errs == 0) begin
            $display("ALL CHECKS PASSED");
        end else begin
            $display("CHECKS FAILED");
        end
        $finish;
    end

    // Watchdog sized from the table length
    initial begin
        int unsigned limit;
        @(posedge clk_i);
        limit = (rows.size() + 20) * 10;
        repeat (limit) @(posedge clk_i);
        $display("timeout: run did not finish within %0d cycles", limit);
        $display("CHECKS FAILED");
        $finish;
    end

endmodule

`default_nettype wire

// ==== all.f ====
source/simd_pkg.sv
source/operand_prep.sv
source/lane_fu.sv
source/latency_tracker.sv
source/result_writeback.sv
source/simd_unit.sv
testbench/clock_gen.sv
testbench/tb_simd_unit.sv

// ==== run.sh ====
#!/bin/sh
# Build and run the testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --timescale 1ns/1ps -j 0 --top-module tb_simd_unit -f all.f
out=$(./obj_dir/Vtb_simd_unit)
echo "$out"
echo "$out" | grep -qx "ALL CHECKS PASSED"
